//--- bench/rv_core_asserts.sv
module rv_core_asserts #(
    parameter int addr_size = 10
) (
    input logic                 CLK,
    input logic                 RESET_N,
    input logic                 mem_read,
    input logic                 mem_write,
    input logic [addr_size-3:0] iaddr,
    input logic                 take_branch
);

    // a word access is either load or store
    strobe_exclusive: assert property (
        @(posedge CLK) disable iff (!RESET_N) !(mem_read && mem_write)
    ) else $error("mem_read and mem_write high together");

    // pipeline holds only bubbles right after reset
    strobes_idle_after_reset: assert property (
        @(posedge CLK) $rose(RESET_N) |-> (!mem_read && !mem_write)
    ) else $error("memory strobe active in first cycle after reset");

    // sequential fetch unless ex_mem redirected the pc
    fetch_sequential: assert property (
        @(posedge CLK) disable iff (!RESET_N)
        ($past(RESET_N) && !$past(take_branch)) |-> (iaddr == $past(iaddr) + 1'b1)
    ) else $error("iaddr did not advance by one word");

endmodule

bind rv_core rv_core_asserts #(.addr_size(addr_size)) u_asserts (
    .CLK         (CLK),
    .RESET_N     (RESET_N),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .iaddr       (iaddr),
    .take_branch (take_branch)
);

//--- bench/rv_core_tb.sv
module rv_core_tb;

    localparam int addr_size = 10;
    // word address width on the memory ports
    localparam int aw        = addr_size - 2;
    localparam int n_tests   = 6;
    localparam int max_prog  = 24;
    localparam int max_store = 12;

    logic               CLK;
    logic               RESET_N;
    rv_core_pkg::word_t idata;
    logic [aw-1:0]      iaddr;
    logic [aw-1:0]      daddr;
    rv_core_pkg::word_t ddata_r;
    rv_core_pkg::word_t ddata_w;
    logic               mem_write;
    logic               mem_read;

    // memory models, combinational read
    rv_core_pkg::word_t imem [256];
    rv_core_pkg::word_t dmem [256];

    // stimulus table, one row per test
    string              name_tbl    [n_tests];
    rv_core_pkg::word_t prog_tbl    [n_tests][max_prog];
    rv_core_pkg::word_t init_tbl    [n_tests][4];
    int                 nst_tbl     [n_tests];
    logic [aw-1:0]      st_addr_tbl [n_tests][max_store];
    rv_core_pkg::word_t st_data_tbl [n_tests][max_store];
    int                 budget_tbl  [n_tests];
    int                 mid_tbl     [n_tests];

    // builder cursor
    int cur;
    int slot;

    // stores seen on the bus
    logic [aw-1:0]      got_addr [$];
    rv_core_pkg::word_t got_data [$];
    int                 since_release;

    int cycles;
    int limit;
    int word_errs;
    int addr_errs;
    int count_errs;
    int other_errs;

    rv_core #(.addr_size(addr_size)) rv_core_i (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .idata     (idata),
        .iaddr     (iaddr),
        .daddr     (daddr),
        .ddata_r   (ddata_r),
        .ddata_w   (ddata_w),
        .mem_write (mem_write),
        .mem_read  (mem_read)
    );

    assign idata   = imem[iaddr];
    // load data only while the read strobe is up
    assign ddata_r = mem_read ? dmem[daddr] : 'x;

    initial begin
        CLK = 1'b0;
        forever begin
            #20 CLK = ~CLK;
        end
    end

    // store capture, mid cycle when strobes are stable
    always @(negedge CLK) begin
        if (!RESET_N) begin
            since_release = 0;
            if (mem_write) begin
                $display("store strobe active while reset is asserted at time %0t", $time);
                other_errs++;
            end
        end else begin
            if (mem_write) begin
                // slot 0 cannot reach memory before cycle 3
                if (since_release < 3) begin
                    $display("store seen %0d cycles after reset release, too early",
                             since_release);
                    other_errs++;
                end
                got_addr.push_back(daddr);
                got_data.push_back(ddata_w);
                dmem[daddr] = ddata_w;
            end
            since_release++;
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run still going after %0d cycles", limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // instruction encoders
    function automatic rv_core_pkg::word_t r_type(logic [6:0] f7, logic [4:0] rs2,
                                                   logic [4:0] rs1, logic [2:0] f3,
                                                   logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_core_pkg::op_reg};
    endfunction

    function automatic rv_core_pkg::word_t i_type(logic [11:0] imm, logic [4:0] rs1,
                                                   logic [2:0] f3, logic [4:0] rd,
                                                   rv_core_pkg::opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_core_pkg::word_t u_type(logic [19:0] imm, logic [4:0] rd,
                                                   rv_core_pkg::opcode_e op);
        return {imm, rd, op};
    endfunction

    // b and j offsets are in bytes, bit 0 dropped
    function automatic rv_core_pkg::word_t b_type(logic [12:0] off, logic [4:0] rs2,
                                                   logic [4:0] rs1, logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_core_pkg::op_branch};
    endfunction

    function automatic rv_core_pkg::word_t j_type(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_core_pkg::op_jal};
    endfunction

    function automatic rv_core_pkg::word_t lw_inst(logic [4:0] rd, logic [4:0] rs1,
                                                    logic [11:0] off);
        return i_type(off, rs1, 3'b010, rd, rv_core_pkg::op_load);
    endfunction

    function automatic rv_core_pkg::word_t sw_inst(logic [4:0] rs2, logic [4:0] rs1,
                                                    logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], rv_core_pkg::op_store};
    endfunction

    // background data, every address bit shows up
    function automatic rv_core_pkg::word_t fill_word(logic [7:0] a);
        return {8'hd5, a, ~a, a ^ 8'h5a};
    endfunction

    // rv32i arithmetic rules for the expected values
    function automatic rv_core_pkg::word_t ref_alu(logic [2:0] f3, logic alt,
                                                    rv_core_pkg::word_t a,
                                                    rv_core_pkg::word_t b);
        rv_core_pkg::word_t r;
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << b[4:0];
            3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: r = (a < b) ? 32'd1 : 32'd0;
            3'b100: r = a ^ b;
            3'b101: begin
                // sra keeps the sign, srl fills zeros
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic open_entry(int t, string name, int budget);
        cur             = t;
        slot            = 0;
        name_tbl[t]     = name;
        budget_tbl[t]   = budget;
        mid_tbl[t]      = -1;
        nst_tbl[t]      = 0;
        for (int i = 0; i < max_prog; i++) begin
            prog_tbl[t][i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            init_tbl[t][i] = '0;
        end
    endtask

    task automatic emit(rv_core_pkg::word_t w);
        prog_tbl[cur][slot] = w;
        slot++;
    endtask

    task automatic pad_nops(int n);
        repeat (n) emit(i_type(12'd0, 5'd0, 3'd0, 5'd0, rv_core_pkg::op_imm));
    endtask

    task automatic expect_store(logic [aw-1:0] a, rv_core_pkg::word_t d);
        st_addr_tbl[cur][nst_tbl[cur]] = a;
        st_data_tbl[cur][nst_tbl[cur]] = d;
        nst_tbl[cur]++;
    endtask

    // add sub and or xor slt sltu sll srl sra on x1, x2
    task automatic build_reg_ops();
        rv_core_pkg::word_t a;
        rv_core_pkg::word_t b;
        logic [2:0]         f3s [10];
        logic               alts [10];
        f3s  = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
        alts = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        // negative versus positive splits slt from sltu
        a = $urandom | 32'h8000_0000;
        // odd b keeps every shift amount nonzero
        b = ($urandom & 32'h7fff_ffff) | 32'h0000_0001;
        open_entry(0, "register alu", 40);
        init_tbl[0][0] = a;
        init_tbl[0][1] = b;
        emit(lw_inst(5'd1, 5'd0, 12'd0));
        emit(lw_inst(5'd2, 5'd0, 12'd4));
        pad_nops(2);
        for (int k = 0; k < 10; k++) begin
            emit(r_type(alts[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, f3s[k], 5'(3 + k)));
        end
        for (int k = 0; k < 10; k++) begin
            emit(sw_inst(5'(3 + k), 5'd0, 12'((32 + k) * 4)));
            expect_store(aw'(32 + k), ref_alu(f3s[k], alts[k], a, b));
        end
    endtask

    // addi andi ori xori slti sltiu slli srli srai, then lui and auipc
    task automatic build_imm_ops();
        rv_core_pkg::word_t a;
        rv_core_pkg::word_t r;
        rv_core_pkg::word_t exp_val [9];
        logic [19:0]        u;
        logic [19:0]        v;
        logic [11:0]        imm;
        logic [2:0]         f3s [9];
        logic               alts [9];
        f3s  = '{3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
        alts = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        a = $urandom | 32'h8000_0000;
        u = 20'($urandom);
        v = 20'($urandom);
        open_entry(1, "immediate alu", 40);
        init_tbl[1][0] = a;
        emit(lw_inst(5'd1, 5'd0, 12'd0));
        emit(u_type(u, 5'd11, rv_core_pkg::op_lui));
        // auipc sits at byte address 8
        emit(u_type(v, 5'd12, rv_core_pkg::op_auipc));
        for (int k = 0; k < 9; k++) begin
            r = $urandom;
            if (f3s[k] == 3'd1 || f3s[k] == 3'd5) begin
                // nonzero shamt so sign fill shows
                imm = {alts[k] ? 7'h20 : 7'h00, r[4:0] | 5'd1};
            end else begin
                imm = r[11:0];
            end
            exp_val[k] = ref_alu(f3s[k], alts[k], a, {{20{imm[11]}}, imm});
            emit(i_type(imm, 5'd1, f3s[k], 5'(2 + k), rv_core_pkg::op_imm));
        end
        for (int k = 0; k < 9; k++) begin
            emit(sw_inst(5'(2 + k), 5'd0, 12'((64 + k) * 4)));
            expect_store(aw'(64 + k), exp_val[k]);
        end
        emit(sw_inst(5'd11, 5'd0, 12'(73 * 4)));
        expect_store(aw'(73), {u, 12'b0});
        emit(sw_inst(5'd12, 5'd0, 12'(74 * 4)));
        expect_store(aw'(74), 32'd8 + {v, 12'b0});
    endtask

    task automatic build_load_store();
        rv_core_pkg::word_t d;
        d = $urandom;
        open_entry(2, "load store", 30);
        init_tbl[2][1] = d;
        init_tbl[2][2] = $urandom | 32'd1;
        // x6 points at data word 16
        emit(i_type(12'd64, 5'd0, 3'd0, 5'd6, rv_core_pkg::op_imm));
        emit(lw_inst(5'd5, 5'd0, 12'd4));
        // both writes to x0 are dropped
        emit(lw_inst(5'd0, 5'd0, 12'd8));
        emit(i_type(12'd123, 5'd0, 3'd0, 5'd0, rv_core_pkg::op_imm));
        emit(sw_inst(5'd5, 5'd6, 12'd12));
        expect_store(aw'(19), d);
        emit(lw_inst(5'd7, 5'd6, 12'd8));
        emit(sw_inst(5'd0, 5'd6, 12'd20));
        expect_store(aw'(21), '0);
        pad_nops(1);
        emit(sw_inst(5'd7, 5'd6, 12'd24));
        expect_store(aw'(22), fill_word(8'd18));
    endtask

    task automatic build_branches(int t, string name, int budget, int mid);
        rv_core_pkg::word_t r;
        r = $urandom;
        open_entry(t, name, budget);
        mid_tbl[t]     = mid;
        init_tbl[t][0] = r;
        init_tbl[t][1] = r;
        init_tbl[t][2] = r ^ 32'h0000_0100;
        emit(lw_inst(5'd1, 5'd0, 12'd0));
        emit(lw_inst(5'd2, 5'd0, 12'd4));
        emit(lw_inst(5'd3, 5'd0, 12'd8));
        emit(i_type(12'h055, 5'd0, 3'd0, 5'd4, rv_core_pkg::op_imm));
        pad_nops(1);
        // beq taken, slot 5 to slot 10
        emit(b_type(13'd20, 5'd2, 5'd1, 3'b000));
        for (int k = 0; k < 3; k++) begin
            emit(sw_inst(5'd4, 5'd0, 12'((40 + k) * 4)));
            expect_store(aw'(40 + k), 32'h55);
        end
        emit(sw_inst(5'd4, 5'd0, 12'(43 * 4)));
        // bne taken, slot 10 to slot 15
        emit(b_type(13'd20, 5'd3, 5'd1, 3'b001));
        for (int k = 0; k < 3; k++) begin
            emit(sw_inst(5'd4, 5'd0, 12'((44 + k) * 4)));
            expect_store(aw'(44 + k), 32'h55);
        end
        emit(sw_inst(5'd4, 5'd0, 12'(47 * 4)));
        // not taken pair, a wrong redirect would drop words 48 and 49
        emit(b_type(13'd32, 5'd3, 5'd1, 3'b000));
        emit(b_type(13'd28, 5'd2, 5'd1, 3'b001));
        pad_nops(2);
        emit(sw_inst(5'd4, 5'd0, 12'(48 * 4)));
        expect_store(aw'(48), 32'h55);
        emit(sw_inst(5'd4, 5'd0, 12'(49 * 4)));
        expect_store(aw'(49), 32'h55);
    endtask

    task automatic build_jal();
        open_entry(4, "jal", 30);
        emit(i_type(12'h077, 5'd0, 3'd0, 5'd2, rv_core_pkg::op_imm));
        pad_nops(1);
        // jal at byte 8 to byte 28, link is 12
        emit(j_type(21'd20, 5'd1));
        emit(sw_inst(5'd2, 5'd0, 12'(52 * 4)));
        expect_store(aw'(52), 32'h77);
        pad_nops(2);
        emit(sw_inst(5'd0, 5'd0, 12'(60 * 4)));
        emit(sw_inst(5'd1, 5'd0, 12'(50 * 4)));
        expect_store(aw'(50), 32'd12);
        emit(sw_inst(5'd2, 5'd0, 12'(51 * 4)));
        expect_store(aw'(51), 32'h77);
    endtask

    task automatic load_memories(int t);
        for (int a = 0; a < 256; a++) begin
            imem[a] = (a < max_prog) ? prog_tbl[t][a] : '0;
            dmem[a] = (a < 4) ? init_tbl[t][a] : fill_word(8'(a));
        end
    endtask

    task automatic check_word(string what, rv_core_pkg::word_t got,
                              rv_core_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s store data %h, expected %h", $time, what, got, exp);
            word_errs++;
        end
    endtask

    task automatic check_addr(string what, logic [aw-1:0] got, logic [aw-1:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s store address %0d, expected %0d",
                     $time, what, got, exp);
            addr_errs++;
        end
    endtask

    task automatic check_count(string what, int got, int exp);
        if (got != exp) begin
            $display("ERROR at %0t: %s saw %0d stores, expected %0d", $time, what, got, exp);
            count_errs++;
        end
    endtask

    task automatic compare_stores(int t);
        int n;
        check_count(name_tbl[t], got_addr.size(), nst_tbl[t]);
        n = (got_addr.size() < nst_tbl[t]) ? got_addr.size() : nst_tbl[t];
        for (int i = 0; i < n; i++) begin
            check_addr(name_tbl[t], got_addr[i], st_addr_tbl[t][i]);
            check_word(name_tbl[t], got_data[i], st_data_tbl[t][i]);
        end
    endtask

    initial begin
        int seed_val;
        RESET_N    = 1'b0;
        cycles     = 0;
        word_errs  = 0;
        addr_errs  = 0;
        count_errs = 0;
        other_errs = 0;
        seed_val   = $urandom(58);
        build_reg_ops();
        build_imm_ops();
        build_load_store();
        build_branches(3, "branches", 40, -1);
        build_jal();
        // same branch program, reset 14 cycles in
        build_branches(5, "mid-run reset", 60, 14);
        limit = 16 + 50;
        for (int t = 0; t < n_tests; t++) begin
            limit += budget_tbl[t] + 4;
        end
        for (int t = 0; t < n_tests; t++) begin
            if (t > 0) begin
                @(posedge CLK);
                #1 RESET_N = 1'b0;
            end
            load_memories(t);
            got_addr.delete();
            got_data.delete();
            repeat ((t == 0) ? 16 : 2) @(posedge CLK);
            #1 RESET_N = 1'b1;
            for (int c = 0; c < budget_tbl[t]; c++) begin
                @(posedge CLK);
                #1;
                if (c == mid_tbl[t]) begin
                    // earlier stores are discarded, the rerun must repeat them
                    RESET_N = 1'b0;
                    got_addr.delete();
                    got_data.delete();
                    repeat (2) @(posedge CLK);
                    #1 RESET_N = 1'b1;
                end
            end
            compare_stores(t);
        end
        $display("errors: data %0d, address %0d, count %0d, other %0d",
                 word_errs, addr_errs, count_errs, other_errs);
        if (word_errs + addr_errs + count_errs + other_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- hw/rv_alu.sv
module rv_alu (
    input  rv_core_pkg::word_t   a,
    input  rv_core_pkg::word_t   b,
    input  rv_core_pkg::alu_op_e op,
    output rv_core_pkg::word_t   result,
    output logic                 zero
);

    // shift amount, low five bits only
    logic [4:0] shamt;
    // compare results
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            rv_core_pkg::alu_add:    result = a + b;
            rv_core_pkg::alu_sub:    result = a - b;
            rv_core_pkg::alu_and:    result = a & b;
            rv_core_pkg::alu_or:     result = a | b;
            rv_core_pkg::alu_xor:    result = a ^ b;
            // set-less-than gives 0 or 1
            rv_core_pkg::alu_slt: begin
                result = {{(rv_core_pkg::xlen-1){1'b0}}, lt_signed};
            end
            rv_core_pkg::alu_sltu: begin
                result = {{(rv_core_pkg::xlen-1){1'b0}}, lt_unsigned};
            end
            rv_core_pkg::alu_sll:    result = a << shamt;
            rv_core_pkg::alu_srl:    result = a >> shamt;
            // arithmetic shift fills with the sign bit
            rv_core_pkg::alu_sra:    result = $signed(a) >>> shamt;
            rv_core_pkg::alu_pass_b: result = b;
            default:                 result = '0;
        endcase
    end

    // used for beq and bne after a subtract
    assign zero = (result == '0);

endmodule

//--- hw/rv_control.sv
module rv_control (
    input  rv_core_pkg::word_t   inst,
    output logic                 branch,
    output logic                 jump,
    output logic                 reg_write,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic                 alu_src,
    output rv_core_pkg::a_sel_e  a_sel,
    output rv_core_pkg::wb_sel_e wb_sel,
    output rv_core_pkg::alu_op_e alu_op
);

    rv_core_pkg::opcode_e opcode;
    logic [2:0]           funct3;
    // funct7 bit 5, picks sub and sra
    logic                 bit30;

    assign opcode = rv_core_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign bit30  = inst[30];

    // alu operation for register and immediate arithmetic
    function automatic rv_core_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        rv_core_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
            3'b001:  op = rv_core_pkg::alu_sll;
            3'b010:  op = rv_core_pkg::alu_slt;
            3'b011:  op = rv_core_pkg::alu_sltu;
            3'b100:  op = rv_core_pkg::alu_xor;
            3'b101:  op = alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
            3'b110:  op = rv_core_pkg::alu_or;
            default: op = rv_core_pkg::alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        // defaults give a bubble
        branch    = 1'b0;
        jump      = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        alu_src   = 1'b0;
        a_sel     = rv_core_pkg::a_rs1;
        wb_sel    = rv_core_pkg::wb_alu;
        alu_op    = rv_core_pkg::alu_add;
        case (opcode)
            rv_core_pkg::op_reg: begin
                reg_write = 1'b1;
                alu_op    = arith_op(funct3, bit30);
            end
            rv_core_pkg::op_imm: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                // bit 30 is immediate data except on srai
                alu_op    = arith_op(funct3, (funct3 == 3'b101) && bit30);
            end
            rv_core_pkg::op_load: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                alu_src   = 1'b1;
                wb_sel    = rv_core_pkg::wb_mem;
            end
            rv_core_pkg::op_store: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
            end
            rv_core_pkg::op_branch: begin
                // subtract, zero flag decides
                branch    = 1'b1;
                alu_op    = rv_core_pkg::alu_sub;
            end
            rv_core_pkg::op_lui: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                a_sel     = rv_core_pkg::a_zero;
                alu_op    = rv_core_pkg::alu_pass_b;
            end
            rv_core_pkg::op_auipc: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                a_sel     = rv_core_pkg::a_pc;
            end
            rv_core_pkg::op_jal: begin
                // link register gets pc plus 4
                jump      = 1'b1;
                reg_write = 1'b1;
                wb_sel    = rv_core_pkg::wb_pc4;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hw/rv_core.sv
module rv_core #(
    parameter int addr_size = 10
) (
    input  logic                 CLK,
    input  logic                 RESET_N,
    input  rv_core_pkg::word_t   idata,
    output logic [addr_size-3:0] iaddr,
    output logic [addr_size-3:0] daddr,
    input  rv_core_pkg::word_t   ddata_r,
    output rv_core_pkg::word_t   ddata_w,
    output logic                 mem_write,
    output logic                 mem_read
);

    // fetch
    logic [addr_size-1:0] pc;
    logic [addr_size-1:0] pc_plus4;
    logic [addr_size-1:0] next_pc;
    logic                 take_branch;

    // decode
    logic [addr_size-1:0] pc_id;
    rv_core_pkg::word_t   inst_id;
    logic                 branch_id, jump_id, reg_write_id;
    logic                 mem_read_id, mem_write_id, alu_src_id;
    rv_core_pkg::a_sel_e  a_sel_id;
    rv_core_pkg::wb_sel_e wb_sel_id;
    rv_core_pkg::alu_op_e alu_op_id;
    rv_core_pkg::word_t   rs1_data_id, rs2_data_id, imm_id;

    // execute
    logic                 branch_ex, jump_ex, reg_write_ex, bne_ex;
    logic                 mem_read_ex, mem_write_ex, alu_src_ex;
    rv_core_pkg::a_sel_e  a_sel_ex;
    rv_core_pkg::wb_sel_e wb_sel_ex;
    rv_core_pkg::alu_op_e alu_op_ex;
    logic [addr_size-1:0] pc_ex;
    rv_core_pkg::word_t   rs1_data_ex, rs2_data_ex, imm_ex;
    logic [4:0]           rd_ex;
    rv_core_pkg::word_t   op_a, op_b, alu_res_ex;
    logic                 zero_ex;
    logic [addr_size-1:0] target_ex, pc4_ex;

    // memory
    logic                 branch_mem, jump_mem, reg_write_mem, bne_mem;
    logic                 mem_read_mem, mem_write_mem;
    rv_core_pkg::wb_sel_e wb_sel_mem;
    rv_core_pkg::word_t   alu_res_mem, rs2_data_mem;
    logic                 zero_mem;
    logic [addr_size-1:0] target_mem, pc4_mem;
    logic [4:0]           rd_mem;

    // writeback
    logic                 reg_write_wb;
    rv_core_pkg::wb_sel_e wb_sel_wb;
    rv_core_pkg::word_t   load_data_wb, alu_res_wb, wb_data;
    logic [addr_size-1:0] pc4_wb;
    logic [4:0]           rd_wb;

    // pc and next fetch address
    assign pc_plus4 = pc + addr_size'(4);
    assign next_pc  = take_branch ? target_mem : pc_plus4;
    assign iaddr    = pc[addr_size-1:2];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc      <= '0;
            // zero word decodes as a bubble
            inst_id <= '0;
        end else begin
            pc      <= next_pc;
            inst_id <= idata;
        end
    end

    always_ff @(posedge CLK) begin
        pc_id <= pc;
    end

    rv_control u_control (
        .inst      (inst_id),
        .branch    (branch_id),
        .jump      (jump_id),
        .reg_write (reg_write_id),
        .mem_read  (mem_read_id),
        .mem_write (mem_write_id),
        .alu_src   (alu_src_id),
        .a_sel     (a_sel_id),
        .wb_sel    (wb_sel_id),
        .alu_op    (alu_op_id)
    );

    // write port driven from mem_wb
    rv_regfile u_regfile (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .rs1_addr (inst_id[19:15]),
        .rs2_addr (inst_id[24:20]),
        .rd_addr  (rd_wb),
        .rd_data  (wb_data),
        .we       (reg_write_wb),
        .rs1_data (rs1_data_id),
        .rs2_data (rs2_data_id)
    );

    rv_imm_gen u_imm_gen (
        .inst (inst_id),
        .imm  (imm_id)
    );

    // id_ex control
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            branch_ex    <= 1'b0;
            jump_ex      <= 1'b0;
            reg_write_ex <= 1'b0;
            mem_read_ex  <= 1'b0;
            mem_write_ex <= 1'b0;
            alu_src_ex   <= 1'b0;
            bne_ex       <= 1'b0;
            a_sel_ex     <= rv_core_pkg::a_rs1;
            wb_sel_ex    <= rv_core_pkg::wb_alu;
            alu_op_ex    <= rv_core_pkg::alu_add;
        end else begin
            branch_ex    <= branch_id;
            jump_ex      <= jump_id;
            reg_write_ex <= reg_write_id;
            mem_read_ex  <= mem_read_id;
            mem_write_ex <= mem_write_id;
            alu_src_ex   <= alu_src_id;
            // funct3 bit 0 separates bne from beq
            bne_ex       <= inst_id[12];
            a_sel_ex     <= a_sel_id;
            wb_sel_ex    <= wb_sel_id;
            alu_op_ex    <= alu_op_id;
        end
    end

    // id_ex data
    always_ff @(posedge CLK) begin
        pc_ex       <= pc_id;
        rs1_data_ex <= rs1_data_id;
        rs2_data_ex <= rs2_data_id;
        imm_ex      <= imm_id;
        rd_ex       <= inst_id[11:7];
    end

    // operand selection
    always_comb begin
        case (a_sel_ex)
            rv_core_pkg::a_pc:   op_a = rv_core_pkg::word_t'(pc_ex);
            rv_core_pkg::a_zero: op_a = '0;
            default:             op_a = rs1_data_ex;
        endcase
    end

    assign op_b = alu_src_ex ? imm_ex : rs2_data_ex;

    rv_alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (alu_op_ex),
        .result (alu_res_ex),
        .zero   (zero_ex)
    );

    // branch or jal target, and link value
    assign target_ex = pc_ex + imm_ex[addr_size-1:0];
    assign pc4_ex    = pc_ex + addr_size'(4);

    // ex_mem control
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            branch_mem    <= 1'b0;
            jump_mem      <= 1'b0;
            reg_write_mem <= 1'b0;
            mem_read_mem  <= 1'b0;
            mem_write_mem <= 1'b0;
            bne_mem       <= 1'b0;
            wb_sel_mem    <= rv_core_pkg::wb_alu;
        end else begin
            branch_mem    <= branch_ex;
            jump_mem      <= jump_ex;
            reg_write_mem <= reg_write_ex;
            mem_read_mem  <= mem_read_ex;
            mem_write_mem <= mem_write_ex;
            bne_mem       <= bne_ex;
            wb_sel_mem    <= wb_sel_ex;
        end
    end

    // ex_mem data
    always_ff @(posedge CLK) begin
        alu_res_mem  <= alu_res_ex;
        zero_mem     <= zero_ex;
        target_mem   <= target_ex;
        pc4_mem      <= pc4_ex;
        rs2_data_mem <= rs2_data_ex;
        rd_mem       <= rd_ex;
    end

    // data memory, word addressed
    assign daddr     = alu_res_mem[addr_size-1:2];
    assign ddata_w   = rs2_data_mem;
    assign mem_write = mem_write_mem;
    assign mem_read  = mem_read_mem;

    // redirect the pc on jal, beq equal or bne not equal
    assign take_branch = jump_mem | (branch_mem & (bne_mem ? ~zero_mem : zero_mem));

    // mem_wb control
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            reg_write_wb <= 1'b0;
            wb_sel_wb    <= rv_core_pkg::wb_alu;
        end else begin
            reg_write_wb <= reg_write_mem;
            wb_sel_wb    <= wb_sel_mem;
        end
    end

    // mem_wb data, load word sampled here
    always_ff @(posedge CLK) begin
        load_data_wb <= ddata_r;
        alu_res_wb   <= alu_res_mem;
        pc4_wb       <= pc4_mem;
        rd_wb        <= rd_mem;
    end

    // writeback source
    always_comb begin
        case (wb_sel_wb)
            rv_core_pkg::wb_mem: wb_data = load_data_wb;
            rv_core_pkg::wb_pc4: wb_data = rv_core_pkg::word_t'(pc4_wb);
            default:             wb_data = alu_res_wb;
        endcase
    end

endmodule

//--- hw/rv_core_pkg.sv
package rv_core_pkg;

    // rv32 data path width
    localparam int xlen = 32;

    // data, immediates and alu results
    typedef logic [xlen-1:0] word_t;

    // major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    // alu operations
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sltu   = 4'd6,
        alu_sll    = 4'd7,
        alu_srl    = 4'd8,
        alu_sra    = 4'd9,
        // lui passes the immediate straight through
        alu_pass_b = 4'd10
    } alu_op_e;

    // writeback source
    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        // link value for jal
        wb_pc4 = 2'd2
    } wb_sel_e;

    // first alu operand
    typedef enum logic [1:0] {
        a_rs1  = 2'd0,
        // auipc adds to the pc
        a_pc   = 2'd1,
        // lui ignores rs1
        a_zero = 2'd2
    } a_sel_e;

endpackage

//--- hw/rv_imm_gen.sv
module rv_imm_gen (
    input  rv_core_pkg::word_t inst,
    output rv_core_pkg::word_t imm
);

    // layout picked from the instruction's own opcode
    rv_core_pkg::opcode_e opcode;

    assign opcode = rv_core_pkg::opcode_e'(inst[6:0]);

    always_comb begin
        case (opcode)
            // i format, alu immediates and loads
            rv_core_pkg::op_imm,
            rv_core_pkg::op_load: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            // s format, offset split around rs2
            rv_core_pkg::op_store: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            // b format, even offsets only
            rv_core_pkg::op_branch: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            // u format, upper twenty bits
            rv_core_pkg::op_lui,
            rv_core_pkg::op_auipc: begin
                imm = {inst[31:12], 12'b0};
            end
            // j format, scrambled 21 bit offset
            rv_core_pkg::op_jal: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            // register ops carry no immediate
            default: imm = '0;
        endcase
    end

endmodule

//--- hw/rv_regfile.sv
module rv_regfile (
    input  logic               CLK,
    input  logic               RESET_N,
    input  logic [4:0]         rs1_addr,
    input  logic [4:0]         rs2_addr,
    input  logic [4:0]         rd_addr,
    input  rv_core_pkg::word_t rd_data,
    input  logic               we,
    output rv_core_pkg::word_t rs1_data,
    output rv_core_pkg::word_t rs2_data
);

    // x1 to x31, x0 is not stored
    rv_core_pkg::word_t regs [1:31];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != 5'd0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 reads zero, same cycle write is bypassed
    function automatic rv_core_pkg::word_t read_port(input logic [4:0] addr);
        rv_core_pkg::word_t value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (we && (addr == rd_addr)) begin
            value = rd_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb rs1_data = read_port(rs1_addr);
    always_comb rs2_data = read_port(rs2_addr);

endmodule

//--- rv_core.f
hw/rv_core_pkg.sv
hw/rv_alu.sv
hw/rv_imm_gen.sv
hw/rv_control.sv
hw/rv_regfile.sv
hw/rv_core.sv
bench/rv_core_asserts.sv
bench/rv_core_tb.sv
